// ==== list.f ====
src/alu_pkg.sv
src/ooo_pkg.sv
src/cdb_if.sv
src/reservation_station.sv
src/alu_unit.sv
src/cdb_arbiter.sv
src/exec_cluster.sv
verif/exec_cluster_props.sv
verif/exec_cluster_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_cluster_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f list.f --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/exec_cluster_tb.sv ====
module exec_cluster_tb;
  import alu_pkg::*;
  import ooo_pkg::*;

  localparam int RS_DEPTH = 3;
  localparam int NTAG     = 2 ** TAG_W;
  localparam int LIMIT    = 200; // cycles allowed for any one wait

  logic              clk_in = 1'b0;
  logic              rst_in = 1'b1;
  logic              issue_valid [2];
  alu_op_e           issue_op    [2];
  logic [TAG_W-1:0]  issue_tag   [2];
  src_operand_t      issue_src1  [2];
  src_operand_t      issue_src2  [2];
  logic              credit      [2];
  logic              ext_wb_valid, ext_wb_ready, cdb_valid;
  logic [TAG_W-1:0]  ext_wb_tag, cdb_tag;
  logic [DATA_W-1:0] ext_wb_value, cdb_value;

  logic [31:0]       seed = 32'd62;
  logic              timed_out = 1'b0;
  int                errors = 0;
  int                timeouts = 0;
  int                credits   [2]; // dispatcher view of free station entries
  int                issues    [2];
  int                credit_rx [2];
  logic [NTAG-1:0]   outstanding = '0;
  logic [NTAG-1:0]   in_order = '0;    // ready at issue, keeps lane order
  logic [NTAG-1:0]   wait_mask [NTAG]; // producers a tag still waits for
  int                lane_of   [NTAG];
  logic [DATA_W-1:0] exp_val   [NTAG];
  int                order_q   [2][$];

  exec_cluster #(.RS_DEPTH(RS_DEPTH)) i_dut (
    .clk_in, .rst_in,
    .issue_valid_0(issue_valid[0]), .issue_op_0(issue_op[0]), .issue_tag_0(issue_tag[0]),
    .issue_src1_0(issue_src1[0]), .issue_src2_0(issue_src2[0]), .credit_0(credit[0]),
    .issue_valid_1(issue_valid[1]), .issue_op_1(issue_op[1]), .issue_tag_1(issue_tag[1]),
    .issue_src1_1(issue_src1[1]), .issue_src2_1(issue_src2[1]), .credit_1(credit[1]),
    .ext_wb_valid, .ext_wb_tag, .ext_wb_value, .ext_wb_ready,
    .cdb_valid, .cdb_tag, .cdb_value
  );

  always #5 clk_in = ~clk_in;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed ^ (seed >> 16); // fold the better high bits down
  endfunction

  // reference results written from the ISA rules
  function automatic logic [DATA_W-1:0] model_result(alu_op_e op, logic [DATA_W-1:0] a,
                                                     logic [DATA_W-1:0] b);
    int   sh;
    logic lt_s;
    sh   = int'(b[4:0]);
    lt_s = (a[DATA_W-1] != b[DATA_W-1]) ? a[DATA_W-1] : (a < b); // sign decides first
    case (op)
      add:     return a + b;
      sub:     return a + ~b + 1;
      and_op:  return a & b;
      or_op:   return a | b;
      xor_op:  return a ^ b;
      slt:     return DATA_W'(lt_s);
      sltu:    return DATA_W'(a < b);
      sll:     return a << sh;
      srl:     return a >> sh;
      sra:     return (a >> sh) | (~({DATA_W{1'b1}} >> sh) & {DATA_W{a[DATA_W-1]}});
      default: return '0;
    endcase
  endfunction

  task automatic tick_or_timeout(inout int n, input string what);
    @(posedge clk_in);
    #1;
    n++;
    if (n >= LIMIT && !timed_out) begin
      $display("timeout after %0d cycles while waiting for %s", n, what);
      timeouts++;
      timed_out = 1'b1;
    end
  endtask

  task automatic alloc_tag(output int t);
    int n;
    n = 0;
    t = -1;
    while (t < 0 && !timed_out) begin
      for (int i = NTAG - 1; i >= 0; i--) begin
        if (!outstanding[i])
          t = i;
      end
      if (t < 0)
        tick_or_timeout(n, "a free tag");
    end
    if (t < 0)
      t = 0;
  endtask

  // tag produced by the load unit outside the cluster
  task automatic reserve_ext(output int e);
    alloc_tag(e);
    exp_val[e]     = next_rand();
    outstanding[e] = 1'b1;
    in_order[e]    = 1'b0;
    wait_mask[e]   = '0;
  endtask

  // p1 and p2 name producer tags, -1 means the operand is a plain value
  task automatic send_instr(input int lane, input alu_op_e op, input int p1, input int p2,
                            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                            output int t);
    int                n;
    logic [DATA_W-1:0] va;
    logic [DATA_W-1:0] vb;
    n = 0;
    while (credits[lane] == 0 && !timed_out)
      tick_or_timeout(n, "an issue credit");
    alloc_tag(t);
    va = (p1 >= 0) ? exp_val[p1] : a;
    vb = (p2 >= 0) ? exp_val[p2] : b;
    issue_src1[lane].ready      = !(p1 >= 0 && outstanding[p1]);
    issue_src2[lane].ready      = !(p2 >= 0 && outstanding[p2]);
    issue_src1[lane].opnd.value = issue_src1[lane].ready ? va : DATA_W'(p1);
    issue_src2[lane].opnd.value = issue_src2[lane].ready ? vb : DATA_W'(p2);
    wait_mask[t] = '0;
    if (!issue_src1[lane].ready)
      wait_mask[t][p1] = 1'b1;
    if (!issue_src2[lane].ready)
      wait_mask[t][p2] = 1'b1;
    exp_val[t]     = model_result(op, va, vb);
    lane_of[t]     = lane;
    outstanding[t] = 1'b1;
    in_order[t]    = issue_src1[lane].ready && issue_src2[lane].ready;
    if (in_order[t])
      order_q[lane].push_back(t);
    issue_op[lane]    = op;
    issue_tag[lane]   = TAG_W'(t);
    issue_valid[lane] = 1'b1;
    credits[lane]--;
    issues[lane]++;
    @(posedge clk_in);
    #1;
    issue_valid[lane] = 1'b0;
  endtask

  task automatic ext_writeback(input int t);
    int   n;
    logic granted;
    n            = 0;
    granted      = 1'b0;
    ext_wb_tag   = TAG_W'(t);
    ext_wb_value = exp_val[t];
    ext_wb_valid = 1'b1; // held until the arbiter grants it
    while (!granted && !timed_out) begin
      @(negedge clk_in);
      granted = ext_wb_ready;
      tick_or_timeout(n, "the external writeback grant");
    end
    ext_wb_valid = 1'b0;
  endtask

  task automatic drain_results();
    int n;
    n = 0;
    while (outstanding != '0 && !timed_out)
      tick_or_timeout(n, "outstanding results");
  endtask

  task automatic check_broadcast(input int t);
    assert (outstanding[t]) else begin
      $display("broadcast for tag %0d, which is not outstanding", t);
      errors++;
    end
    assert (cdb_value == exp_val[t]) else begin
      $display("CHECK FAILED cdb_value tag %0d: got %h, expected %h", t, cdb_value, exp_val[t]);
      errors++;
    end
    assert (wait_mask[t] == '0) else begin
      $display("tag %0d was broadcast before its producer", t);
      errors++;
    end
    if (in_order[t]) begin
      assert (order_q[lane_of[t]].size() > 0 && order_q[lane_of[t]][0] == t) else begin
        $display("tag %0d left lane %0d out of issue order", t, lane_of[t]);
        errors++;
      end
      if (order_q[lane_of[t]].size() > 0)
        void'(order_q[lane_of[t]].pop_front());
    end
    outstanding[t] = 1'b0;
    in_order[t]    = 1'b0;
    for (int c = 0; c < NTAG; c++) begin
      wait_mask[c][t] = 1'b0; // consumers of t are woken now
    end
  endtask

  // mid-cycle sampling of credits and the CDB
  always @(negedge clk_in) begin
    if (!rst_in) begin
      for (int l = 0; l < 2; l++) begin
        if (credit[l]) begin
          credits[l]++;
          credit_rx[l]++;
        end
      end
      if (cdb_valid)
        check_broadcast(int'(cdb_tag));
    end
  end

  initial begin
    int t;
    int e;
    int rx_before;
    int ch [4];
    for (int l = 0; l < 2; l++) begin
      issue_valid[l] = 1'b0;
      issue_op[l]    = add;
      issue_tag[l]   = '0;
      issue_src1[l]  = '0;
      issue_src2[l]  = '0;
      credits[l]     = RS_DEPTH;
      issues[l]      = 0;
      credit_rx[l]   = 0;
    end
    for (int i = 0; i < NTAG; i++) begin
      wait_mask[i] = '0;
    end
    ext_wb_valid = 1'b0;
    ext_wb_tag   = '0;
    ext_wb_value = '0;
    repeat (3) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    // every op with ready operands, both lanes
    for (int i = 0; i < 20; i++) begin
      send_instr((i / 10 + i) % 2, alu_op_e'(4'(i % 10)), -1, -1, next_rand(), next_rand(), t);
    end
    drain_results();

    // dependent chain across lanes
    send_instr(0, add, -1, -1, next_rand(), next_rand(), ch[0]);
    send_instr(1, sub, ch[0], -1, 0, next_rand(), ch[1]);
    send_instr(0, xor_op, ch[1], ch[0], 0, 0, ch[2]);
    send_instr(1, sra, ch[2], -1, 0, 32'd7, ch[3]);
    drain_results();

    // station 0 fills with entries that wait on a load result
    reserve_ext(e);
    for (int i = 0; i < RS_DEPTH; i++) begin
      send_instr(0, or_op, e, -1, 0, next_rand(), t);
    end
    rx_before = credit_rx[0];
    repeat (8) @(posedge clk_in);
    #1;
    assert (credits[0] == 0 && credit_rx[0] == rx_before) else begin
      $display("lane 0 returned a credit while its entries wait on tag %0d", e);
      errors++;
    end
    ext_writeback(e);
    drain_results();

    // external writeback against two streaming lanes
    reserve_ext(e);
    fork
      for (int i = 0; i < 8; i++) begin
        send_instr(0, alu_op_e'(4'(next_rand() % 10)), -1, -1, next_rand(), next_rand(), ch[0]);
      end
      for (int j = 0; j < 8; j++) begin
        send_instr(1, alu_op_e'(4'(next_rand() % 10)), -1, -1, next_rand(), next_rand(), ch[1]);
      end
      begin
        repeat (4) @(posedge clk_in);
        #1;
        ext_writeback(e);
      end
    join
    drain_results();

    for (int l = 0; l < 2; l++) begin
      assert (credit_rx[l] == issues[l]) else begin
        $display("lane %0d returned %0d credits for %0d issues", l, credit_rx[l], issues[l]);
        errors++;
      end
    end
    $display("errors: %0d check, %0d timeout, %0d protocol", errors, timeouts,
             i_dut.i_props.fail_cnt);
    if (errors == 0 && timeouts == 0 && i_dut.i_props.fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verif/exec_cluster_props.sv ====
module exec_cluster_props #(
  parameter int RS_DEPTH = 3
) (
  input logic                          clk_in,
  input logic                          rst_in,
  input logic                          issue_valid_0,
  input logic                          issue_valid_1,
  input logic                          credit_0,
  input logic                          credit_1,
  input logic                          cdb_valid,
  input logic                          alu_req_0,
  input logic                          alu_req_1,
  input logic                          alu_gnt_0,
  input logic                          alu_gnt_1,
  input ooo_pkg::cdb_pkt_t             alu_pkt_0,
  input ooo_pkg::cdb_pkt_t             alu_pkt_1,
  input logic                          ext_wb_valid,
  input logic                          ext_wb_ready,
  input logic [ooo_pkg::TAG_W-1:0]     ext_wb_tag,
  input logic [alu_pkg::DATA_W-1:0]    ext_wb_value,
  input logic [$clog2(RS_DEPTH+1)-1:0] free_cnt_0,
  input logic [$clog2(RS_DEPTH+1)-1:0] free_cnt_1
);

  int   fail_cnt = 0; // failed assertion count
  logic issued_q;     // any issue seen since reset

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      issued_q <= 1'b0;
    end else if (issue_valid_0 || issue_valid_1) begin
      issued_q <= 1'b1;
    end
  end

  quiet_before_issue: assert property (@(posedge clk_in) disable iff (rst_in)
    !issued_q |-> !cdb_valid && !credit_0 && !credit_1)
  else begin
    $error("credit pulse or broadcast before the first issue");
    fail_cnt++;
  end

  issue_has_room: assert property (@(posedge clk_in) disable iff (rst_in)
    !(issue_valid_0 && free_cnt_0 == '0) && !(issue_valid_1 && free_cnt_1 == '0))
  else begin
    $error("issue into a station with no free entry");
    fail_cnt++;
  end

  ext_held_until_ready: assert property (@(posedge clk_in) disable iff (rst_in)
    ext_wb_valid && !ext_wb_ready |=>
      ext_wb_valid && $stable(ext_wb_tag) && $stable(ext_wb_value))
  else begin
    $error("external writeback dropped or changed before its grant");
    fail_cnt++;
  end

  // a result that misses the bus stays in stage 2 unchanged
  alu0_held_until_grant: assert property (@(posedge clk_in) disable iff (rst_in)
    alu_req_0 && !alu_gnt_0 |=> alu_req_0 && $stable(alu_pkt_0))
  else begin
    $error("lane 0 result dropped or changed before its grant");
    fail_cnt++;
  end

  alu1_held_until_grant: assert property (@(posedge clk_in) disable iff (rst_in)
    alu_req_1 && !alu_gnt_1 |=> alu_req_1 && $stable(alu_pkt_1))
  else begin
    $error("lane 1 result dropped or changed before its grant");
    fail_cnt++;
  end

endmodule

bind exec_cluster exec_cluster_props #(.RS_DEPTH(RS_DEPTH)) i_props (
  .clk_in, .rst_in, .issue_valid_0, .issue_valid_1, .credit_0, .credit_1, .cdb_valid,
  .alu_req_0(wb_0.req), .alu_req_1(wb_1.req), .alu_gnt_0(wb_0.gnt), .alu_gnt_1(wb_1.gnt),
  .alu_pkt_0(wb_0.pkt), .alu_pkt_1(wb_1.pkt), .ext_wb_valid, .ext_wb_ready, .ext_wb_tag,
  .ext_wb_value, .free_cnt_0(i_rs_0.free_cnt), .free_cnt_1(i_rs_1.free_cnt)
);

// ==== src/exec_cluster.sv ====
module exec_cluster #(
  parameter int RS_DEPTH = 3
) (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       issue_valid_0,
  input  alu_pkg::alu_op_e           issue_op_0,
  input  logic [ooo_pkg::TAG_W-1:0]  issue_tag_0,
  input  ooo_pkg::src_operand_t      issue_src1_0,
  input  ooo_pkg::src_operand_t      issue_src2_0,
  output logic                       credit_0,
  input  logic                       issue_valid_1,
  input  alu_pkg::alu_op_e           issue_op_1,
  input  logic [ooo_pkg::TAG_W-1:0]  issue_tag_1,
  input  ooo_pkg::src_operand_t      issue_src1_1,
  input  ooo_pkg::src_operand_t      issue_src2_1,
  output logic                       credit_1,
  input  logic                       ext_wb_valid,
  input  logic [ooo_pkg::TAG_W-1:0]  ext_wb_tag,
  input  logic [alu_pkg::DATA_W-1:0] ext_wb_value,
  output logic                       ext_wb_ready,
  output logic                       cdb_valid,
  output logic [ooo_pkg::TAG_W-1:0]  cdb_tag,
  output logic [alu_pkg::DATA_W-1:0] cdb_value
);
  import alu_pkg::*;
  import ooo_pkg::*;

  logic              disp_valid_0, disp_valid_1;
  alu_op_e           disp_op_0, disp_op_1;
  logic [TAG_W-1:0]  disp_tag_0, disp_tag_1;
  logic [DATA_W-1:0] disp_a_0, disp_a_1;
  logic [DATA_W-1:0] disp_b_0, disp_b_1;
  logic              alu_ready_0, alu_ready_1;
  cdb_pkt_t          ext_pkt;
  cdb_pkt_t          bus_pkt; // broadcast seen by both stations

  cdb_if wb_0 ();
  cdb_if wb_1 ();

  assign ext_pkt.tag   = ext_wb_tag;
  assign ext_pkt.value = ext_wb_value;
  assign cdb_tag       = bus_pkt.tag;
  assign cdb_value     = bus_pkt.value;

  reservation_station #(.RS_DEPTH(RS_DEPTH)) i_rs_0 (
    .clk_in, .rst_in, .issue_valid(issue_valid_0), .issue_op(issue_op_0),
    .issue_tag(issue_tag_0), .issue_src1(issue_src1_0), .issue_src2(issue_src2_0),
    .cdb_valid, .cdb_pkt(bus_pkt), .alu_ready(alu_ready_0), .disp_valid(disp_valid_0),
    .disp_op(disp_op_0), .disp_tag(disp_tag_0), .disp_a(disp_a_0), .disp_b(disp_b_0),
    .credit(credit_0)
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH)) i_rs_1 (
    .clk_in, .rst_in, .issue_valid(issue_valid_1), .issue_op(issue_op_1),
    .issue_tag(issue_tag_1), .issue_src1(issue_src1_1), .issue_src2(issue_src2_1),
    .cdb_valid, .cdb_pkt(bus_pkt), .alu_ready(alu_ready_1), .disp_valid(disp_valid_1),
    .disp_op(disp_op_1), .disp_tag(disp_tag_1), .disp_a(disp_a_1), .disp_b(disp_b_1),
    .credit(credit_1)
  );

  alu_unit i_alu_0 (
    .clk_in, .rst_in, .disp_valid(disp_valid_0), .disp_op(disp_op_0),
    .disp_tag(disp_tag_0), .disp_a(disp_a_0), .disp_b(disp_b_0),
    .alu_ready(alu_ready_0), .wb(wb_0)
  );

  alu_unit i_alu_1 (
    .clk_in, .rst_in, .disp_valid(disp_valid_1), .disp_op(disp_op_1),
    .disp_tag(disp_tag_1), .disp_a(disp_a_1), .disp_b(disp_b_1),
    .alu_ready(alu_ready_1), .wb(wb_1)
  );

  cdb_arbiter i_arb (
    .clk_in, .rst_in, .ch0(wb_0), .ch1(wb_1), .ext_req(ext_wb_valid), .ext_pkt,
    .ext_gnt(ext_wb_ready), .cdb_valid, .cdb_pkt(bus_pkt)
  );

endmodule

// ==== src/cdb_arbiter.sv ====
module cdb_arbiter (
  input  logic              clk_in,
  input  logic              rst_in,
  cdb_if.arbiter            ch0,
  cdb_if.arbiter            ch1,
  input  logic              ext_req,
  input  ooo_pkg::cdb_pkt_t ext_pkt,
  output logic              ext_gnt,
  output logic              cdb_valid,
  output ooo_pkg::cdb_pkt_t cdb_pkt
);

  logic [2:0] req;       // ext, ch1, ch0
  logic [2:0] gnt;
  logic [1:0] ptr_q;     // channel with the highest priority
  logic [1:0] grant_idx;

  function automatic logic [1:0] wrap3(logic [1:0] base, logic [1:0] step);
    logic [2:0] sum;
    sum = {1'b0, base} + {1'b0, step};
    return (sum >= 3'd3) ? 2'(sum - 3'd3) : sum[1:0];
  endfunction

  assign req = {ext_req, ch1.req, ch0.req};

  always_comb begin
    gnt       = '0;
    grant_idx = '0;
    for (int k = 0; k < 3; k++) begin
      if ((gnt == '0) && req[wrap3(ptr_q, 2'(k))]) begin
        gnt[wrap3(ptr_q, 2'(k))] = 1'b1;
        grant_idx                = wrap3(ptr_q, 2'(k));
      end
    end
  end

  assign ch0.gnt   = gnt[0];
  assign ch1.gnt   = gnt[1];
  assign ext_gnt   = gnt[2];
  assign cdb_valid = |gnt;
  assign cdb_pkt   = (grant_idx == 2'd0) ? ch0.pkt :
                     (grant_idx == 2'd1) ? ch1.pkt : ext_pkt;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ptr_q <= '0;
    end else if (cdb_valid) begin
      ptr_q <= wrap3(grant_idx, 2'd1); // winner drops to the lowest priority
    end
  end

endmodule

// ==== src/alu_unit.sv ====
module alu_unit (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       disp_valid,
  input  alu_pkg::alu_op_e           disp_op,
  input  logic [ooo_pkg::TAG_W-1:0]  disp_tag,
  input  logic [alu_pkg::DATA_W-1:0] disp_a,
  input  logic [alu_pkg::DATA_W-1:0] disp_b,
  output logic                       alu_ready,
  cdb_if.requester                   wb
);
  import alu_pkg::*;
  import ooo_pkg::*;

  logic              s1_valid;
  alu_op_e           s1_op;
  logic [TAG_W-1:0]  s1_tag;
  logic [DATA_W-1:0] s1_a;
  logic [DATA_W-1:0] s1_b;
  logic              s2_valid;
  cdb_pkt_t          s2_pkt; // result held until granted
  logic              s2_free;

  assign s2_free   = !s2_valid || wb.gnt; // empty now or emptying this cycle
  assign alu_ready = !s1_valid || s2_free;
  assign wb.req    = s2_valid;
  assign wb.pkt    = s2_pkt;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (alu_ready) begin
        s1_valid <= disp_valid;
      end
      if (s2_free) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (disp_valid && alu_ready) begin
      s1_op  <= disp_op;
      s1_tag <= disp_tag;
      s1_a   <= disp_a;
      s1_b   <= disp_b;
    end
    if (s1_valid && s2_free) begin
      s2_pkt.tag   <= s1_tag;
      s2_pkt.value <= alu_eval(s1_op, s1_a, s1_b);
    end
  end

endmodule

// ==== src/reservation_station.sv ====
module reservation_station #(
  parameter int RS_DEPTH = 3
) (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       issue_valid,
  input  alu_pkg::alu_op_e           issue_op,
  input  logic [ooo_pkg::TAG_W-1:0]  issue_tag,
  input  ooo_pkg::src_operand_t      issue_src1,
  input  ooo_pkg::src_operand_t      issue_src2,
  input  logic                       cdb_valid,
  input  ooo_pkg::cdb_pkt_t          cdb_pkt,
  input  logic                       alu_ready,
  output logic                       disp_valid,
  output alu_pkg::alu_op_e           disp_op,
  output logic [ooo_pkg::TAG_W-1:0]  disp_tag,
  output logic [alu_pkg::DATA_W-1:0] disp_a,
  output logic [alu_pkg::DATA_W-1:0] disp_b,
  output logic                       credit
);
  import alu_pkg::*;
  import ooo_pkg::*;

  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
  localparam int CNT_W = $clog2(RS_DEPTH + 1);

  logic             busy   [RS_DEPTH];
  alu_op_e          op_q   [RS_DEPTH];
  logic [TAG_W-1:0] tag_q  [RS_DEPTH];
  src_operand_t     src1_q [RS_DEPTH];
  src_operand_t     src2_q [RS_DEPTH];
  logic [CNT_W-1:0] age_q  [RS_DEPTH]; // 0 is the oldest busy entry

  logic [IDX_W-1:0] free_idx; // lowest free entry, target of the next issue
  logic [CNT_W-1:0] free_cnt;
  logic [IDX_W-1:0] disp_idx;
  logic [CNT_W-1:0] best_age;
  logic             disp_fire;

  // wake a waiting source when its producer tag is on the bus
  function automatic src_operand_t snoop(src_operand_t src, logic bus_valid, cdb_pkt_t pkt);
    src_operand_t res;
    res = src;
    if (!src.ready && bus_valid && (src.opnd.tag.idx == pkt.tag)) begin
      res.ready      = 1'b1;
      res.opnd.value = pkt.value;
    end
    return res;
  endfunction

  always_comb begin
    free_idx = '0;
    free_cnt = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin // downward so the lowest index wins
      if (!busy[i]) begin
        free_idx = IDX_W'(i);
        free_cnt = free_cnt + 1'b1;
      end
    end
  end

  // oldest entry with both sources ready
  always_comb begin
    disp_valid = 1'b0;
    disp_idx   = '0;
    best_age   = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (busy[i] && src1_q[i].ready && src2_q[i].ready &&
          (!disp_valid || (age_q[i] < best_age))) begin
        disp_valid = 1'b1;
        disp_idx   = IDX_W'(i);
        best_age   = age_q[i];
      end
    end
  end

  assign disp_fire = disp_valid && alu_ready;
  assign disp_op   = op_q[disp_idx];
  assign disp_tag  = tag_q[disp_idx];
  assign disp_a    = src1_q[disp_idx].opnd.value;
  assign disp_b    = src2_q[disp_idx].opnd.value;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        busy[i] <= 1'b0;
      end
      credit <= 1'b0;
    end else begin
      credit <= disp_fire; // one pulse, the cycle after the entry leaves
      if (disp_fire) begin
        busy[disp_idx] <= 1'b0;
      end
      if (issue_valid) begin
        busy[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      src1_q[i] <= snoop(src1_q[i], cdb_valid, cdb_pkt);
      src2_q[i] <= snoop(src2_q[i], cdb_valid, cdb_pkt);
      if (disp_fire && (age_q[i] > age_q[disp_idx])) begin
        age_q[i] <= age_q[i] - 1'b1; // younger entries move up one place
      end
    end
    if (issue_valid) begin
      op_q[free_idx]   <= issue_op;
      tag_q[free_idx]  <= issue_tag;
      src1_q[free_idx] <= snoop(issue_src1, cdb_valid, cdb_pkt);
      src2_q[free_idx] <= snoop(issue_src2, cdb_valid, cdb_pkt);
      // new entry sits behind every entry that stays
      age_q[free_idx]  <= CNT_W'(RS_DEPTH) - free_cnt - CNT_W'(disp_fire);
    end
  end

endmodule

// ==== src/cdb_if.sv ====
interface cdb_if;

  // a requester holds req and pkt steady until it sees gnt
  // the gnt cycle is the transfer and the broadcast at once

  logic              req; // result waiting for the bus
  logic              gnt; // combinational grant from the arbiter
  ooo_pkg::cdb_pkt_t pkt; // tag and value to broadcast

  modport requester (
    output req,
    output pkt,
    input  gnt
  );

  modport arbiter (
    input  req,
    input  pkt,
    output gnt
  );

endinterface

// ==== src/ooo_pkg.sv ====
package ooo_pkg;

  localparam int TAG_W = 3; // reorder buffer index width

  // tag view of an operand word, index sits in the low bits
  typedef struct packed {
    logic [alu_pkg::DATA_W-TAG_W-1:0] pad; // zero when the word is a tag
    logic [TAG_W-1:0]                 idx;
  } tag_word_t;

  // one operand word, decoded by the ready bit next to it
  typedef union packed {
    logic [alu_pkg::DATA_W-1:0] value; // ready: operand value
    tag_word_t                  tag;   // not ready: producer tag
  } operand_u;

  typedef struct packed {
    logic     ready; // opnd holds a value when set
    operand_u opnd;
  } src_operand_t;

  // payload broadcast on the common data bus
  typedef struct packed {
    logic [TAG_W-1:0]           tag;
    logic [alu_pkg::DATA_W-1:0] value;
  } cdb_pkt_t;

endpackage

// ==== src/alu_pkg.sv ====
package alu_pkg;

  localparam int DATA_W = 32; // operand and result width

  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    and_op = 4'd2,
    or_op  = 4'd3,
    xor_op = 4'd4,
    slt    = 4'd5,
    sltu   = 4'd6,
    sll    = 4'd7,
    srl    = 4'd8,
    sra    = 4'd9 // codes 10 to 15 are unused
  } alu_op_e;

  function automatic logic [DATA_W-1:0] alu_eval(alu_op_e op, logic [DATA_W-1:0] a,
                                                 logic [DATA_W-1:0] b);
    logic [4:0] shamt;
    shamt = b[4:0]; // shifts only look at the low 5 bits
    case (op)
      add:     return a + b;
      sub:     return a - b;
      and_op:  return a & b;
      or_op:   return a | b;
      xor_op:  return a ^ b;
      slt:     return {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
      sltu:    return {{(DATA_W-1){1'b0}}, a < b};
      sll:     return a << shamt;
      srl:     return a >> shamt;
      sra:     return $signed(a) >>> shamt; // sign bit fills from the left
      default: return '0;
    endcase
  endfunction

endpackage
